//--- include/hawk_cfg.svh
/*
 sizing for the hawk page manager control path
 FREE_PAGES must exceed the number of allocations, since list exhaustion is not detected
*/
`ifndef HAWK_CFG_SVH
`define HAWK_CFG_SVH

// byte address width of the host side
`define HACD_AXI4_ADDR_WIDTH 32

// 4 KB pages
`define HAWK_PG_SHIFT 12

// ATT is indexed by the low hppa bits
`define HAWK_ATT_ENTRIES 16

// free list depth and first free page
`define HAWK_FREE_PAGES 8
`define HAWK_FREE_BASE 256

// shared page backing all-zero writes
`define HAWK_ZERO_PPA 1

`endif

//--- design/hacd_pkg.sv
/*
 packet types shared by the hawk control path
 page numbers are address width minus page shift bits wide
*/
`include "hawk_cfg.svh"

package hacd_pkg;

    // derived widths
    localparam int PPN_W = `HACD_AXI4_ADDR_WIDTH - `HAWK_PG_SHIFT;
    localparam int ATT_IDX_W = $clog2(`HAWK_ATT_ENTRIES);
    localparam int FL_IDX_W = $clog2(`HAWK_FREE_PAGES);
    localparam int FCNT_W = $clog2(`HAWK_FREE_PAGES + 1);

    typedef logic [PPN_W-1:0] ppn_t;
    typedef logic [`HACD_AXI4_ADDR_WIDTH-1:0] addr_t;
    typedef logic [ATT_IDX_W-1:0] att_idx_t;
    typedef logic [FL_IDX_W-1:0] fl_idx_t;
    typedef logic [FCNT_W-1:0] fcnt_t;

    // translation result codes
    typedef enum logic [1:0] {
        STS_HIT   = 2'd0,
        STS_ALLOC = 2'd1,
        STS_ZERO  = 2'd2
    } trnsl_sts_e;

    // cpu request, held as a level until granted
    typedef struct packed {
        logic valid;
        ppn_t hppa;
        logic zeroBlkWr;
    } cpu_reqpkt_t;

    // lookup strobe plus latched request fields
    typedef struct packed {
        logic lookup;
        ppn_t hppa;
        logic zeroBlkWr;
    } att_lkup_reqpkt_t;

    // lookup reply, ppa as a full byte address
    typedef struct packed {
        logic       allow_access;
        addr_t      ppa;
        trnsl_sts_e sts;
    } trnsl_reqpkt_t;

    // allocation report, ppa as a page number
    typedef struct packed {
        logic  valid;
        ppn_t  ppa;
        fcnt_t free_cnt;
    } tol_updpkt_t;

    // grant back to one cpu source
    typedef struct packed {
        logic allow_access;
        ppn_t ppa;
    } hawk_cpu_ovrd_pkt_t;

    // one ATT entry write
    typedef struct packed {
        logic     en;
        att_idx_t idx;
        logic     vld;
        ppn_t     ppa;
    } att_wr_t;

    // page number to byte address
    function automatic addr_t ppn_to_addr(ppn_t ppn);
        return {ppn, {`HAWK_PG_SHIFT{1'b0}}};
    endfunction

endpackage

//--- design/hawk_ctrl_unit.sv
/*
 init sequencing and read/write arbitration; one lookup in flight at a time
 sources must drop valid the cycle after their grant
*/
`timescale 1ns/1ps
`include "hawk_cfg.svh"

module hawk_ctrl_unit import hacd_pkg::*; (
    input  logic               clk_i,
    input  logic               rst_ni,

    // page writer
    input  logic               init_att_done,
    input  logic               init_list_done,
    output logic               init_att,
    output logic               init_list,

    // page read manager
    input  logic               pgrd_mngr_ready,
    input  trnsl_reqpkt_t      trnsl_reqpkt,
    output att_lkup_reqpkt_t   lkup_reqpkt,

    // cpu side
    input  cpu_reqpkt_t        cpu_rd_reqpkt,
    input  cpu_reqpkt_t        cpu_wr_reqpkt,
    output hawk_cpu_ovrd_pkt_t hawk_cpu_ovrd_rdpkt,
    output hawk_cpu_ovrd_pkt_t hawk_cpu_ovrd_wrpkt
);

    typedef enum logic [2:0] {
        IDLE,
        CHK_RD_ACTIVE,
        CHK_WR_ACTIVE,
        RD_LKP_REQ,
        WR_LKP_REQ,
        RD_LOOKUP_ALLOCATE,
        WR_LOOKUP_ALLOCATE
    } state_e;

    state_e             state_q, state_d;
    logic               init_att_d, init_list_d;
    att_lkup_reqpkt_t   lkup_d;
    hawk_cpu_ovrd_pkt_t ovrd_rd_d, ovrd_wr_d;
    logic               rd_req, wr_req;
    ppn_t               trnsl_ppn;

    // a source still holding the grant this cycle has already been served
    assign rd_req = cpu_rd_reqpkt.valid && !hawk_cpu_ovrd_rdpkt.allow_access;
    assign wr_req = cpu_wr_reqpkt.valid && !hawk_cpu_ovrd_wrpkt.allow_access;

    assign trnsl_ppn = trnsl_reqpkt.ppa[`HACD_AXI4_ADDR_WIDTH-1:`HAWK_PG_SHIFT];

    ////////////////////////////////////////////////////////////////////////////
    // next state
    ////////////////////////////////////////////////////////////////////////////
    // with the FSM parked in a check state, the grant lands 4 cycles after
    // the edge that samples the request
    always_comb begin
        state_d     = state_q;
        init_att_d  = init_att;
        init_list_d = init_list;
        // request fields stay latched, strobe is one cycle
        lkup_d        = lkup_reqpkt;
        lkup_d.lookup = 1'b0;
        // granted ppa stays latched, grant is one cycle
        ovrd_rd_d              = hawk_cpu_ovrd_rdpkt;
        ovrd_rd_d.allow_access = 1'b0;
        ovrd_wr_d              = hawk_cpu_ovrd_wrpkt;
        ovrd_wr_d.allow_access = 1'b0;

        case (state_q)
            IDLE: begin
                if (init_att_done) begin
                    init_att_d = 1'b0;
                end
                // list fill is the last init step
                if (init_list_done) begin
                    init_list_d = 1'b0;
                    state_d     = CHK_RD_ACTIVE;
                end
            end
            CHK_RD_ACTIVE: begin
                if (rd_req) begin
                    lkup_d.hppa      = cpu_rd_reqpkt.hppa;
                    lkup_d.zeroBlkWr = 1'b0;
                    state_d          = RD_LKP_REQ;
                end else if (wr_req) begin
                    lkup_d.hppa      = cpu_wr_reqpkt.hppa;
                    lkup_d.zeroBlkWr = cpu_wr_reqpkt.zeroBlkWr;
                    state_d          = WR_LKP_REQ;
                end
            end
            CHK_WR_ACTIVE: begin
                if (wr_req) begin
                    lkup_d.hppa      = cpu_wr_reqpkt.hppa;
                    lkup_d.zeroBlkWr = cpu_wr_reqpkt.zeroBlkWr;
                    state_d          = WR_LKP_REQ;
                end else if (rd_req) begin
                    lkup_d.hppa      = cpu_rd_reqpkt.hppa;
                    lkup_d.zeroBlkWr = 1'b0;
                    state_d          = RD_LKP_REQ;
                end
            end
            RD_LKP_REQ: begin
                if (pgrd_mngr_ready) begin
                    lkup_d.lookup = 1'b1;
                    state_d       = RD_LOOKUP_ALLOCATE;
                end
            end
            WR_LKP_REQ: begin
                if (pgrd_mngr_ready) begin
                    lkup_d.lookup = 1'b1;
                    state_d       = WR_LOOKUP_ALLOCATE;
                end
            end
            RD_LOOKUP_ALLOCATE: begin
                // read served, writes get first look next
                if (trnsl_reqpkt.allow_access) begin
                    ovrd_rd_d.ppa          = trnsl_ppn;
                    ovrd_rd_d.allow_access = 1'b1;
                    state_d                = CHK_WR_ACTIVE;
                end
            end
            WR_LOOKUP_ALLOCATE: begin
                if (trnsl_reqpkt.allow_access) begin
                    ovrd_wr_d.ppa          = trnsl_ppn;
                    ovrd_wr_d.allow_access = 1'b1;
                    state_d                = CHK_RD_ACTIVE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    // state and output registers
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q             <= IDLE;
            init_att            <= 1'b1;
            init_list           <= 1'b1;
            lkup_reqpkt         <= '0;
            hawk_cpu_ovrd_rdpkt <= '0;
            hawk_cpu_ovrd_wrpkt <= '0;
        end else begin
            state_q             <= state_d;
            init_att            <= init_att_d;
            init_list           <= init_list_d;
            lkup_reqpkt         <= lkup_d;
            hawk_cpu_ovrd_rdpkt <= ovrd_rd_d;
            hawk_cpu_ovrd_wrpkt <= ovrd_wr_d;
        end
    end

endmodule

//--- design/hawk_pg_writer.sv
/*
 post-reset init, ATT clear then free list fill, one entry per cycle
 runs once per reset
*/
`timescale 1ns/1ps
`include "hawk_cfg.svh"

module hawk_pg_writer import hacd_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_ni,
    input  logic    init_att,
    input  logic    init_list,
    output logic    init_att_done,
    output logic    init_list_done,
    output att_wr_t pgw_wr,
    output logic    fl_wr_en,
    output fl_idx_t fl_wr_idx,
    output ppn_t    fl_wr_ppa
);

    // one counter walks both tables
    localparam int CNT_W = (ATT_IDX_W > FL_IDX_W) ? ATT_IDX_W : FL_IDX_W;

    logic [CNT_W-1:0] cnt_q;
    logic             att_fin_q, list_fin_q;
    logic             att_busy, list_busy;
    logic             att_last, list_last;

    // list fill starts right after the last ATT write
    assign att_busy  = init_att && !att_fin_q;
    assign list_busy = init_list && att_fin_q && !list_fin_q;
    assign att_last  = att_busy && (cnt_q == CNT_W'(`HAWK_ATT_ENTRIES - 1));
    assign list_last = list_busy && (cnt_q == CNT_W'(`HAWK_FREE_PAGES - 1));

    // every ATT entry starts unmapped
    always_comb begin
        pgw_wr.en  = att_busy;
        pgw_wr.idx = cnt_q[ATT_IDX_W-1:0];
        pgw_wr.vld = 1'b0;
        pgw_wr.ppa = '0;
    end

    // slot i holds FREE_BASE + i
    assign fl_wr_en  = list_busy;
    assign fl_wr_idx = cnt_q[FL_IDX_W-1:0];
    assign fl_wr_ppa = ppn_t'(`HAWK_FREE_BASE) + ppn_t'(cnt_q);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cnt_q          <= '0;
            att_fin_q      <= 1'b0;
            list_fin_q     <= 1'b0;
            init_att_done  <= 1'b0;
            init_list_done <= 1'b0;
        end else begin
            // done pulses follow the last write by one cycle
            init_att_done  <= att_last;
            init_list_done <= list_last;
            if (att_last) begin
                att_fin_q <= 1'b1;
                cnt_q     <= '0;
            end else if (list_last) begin
                list_fin_q <= 1'b1;
                cnt_q      <= '0;
            end else if (att_busy || list_busy) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

endmodule

//--- design/hawk_att_mem.sv
/*
 ATT valid/ppa arrays and free list; registered ATT read, combinational list head
 writer and manager must not write in the same cycle
*/
`timescale 1ns/1ps
`include "hawk_cfg.svh"

module hawk_att_mem import hacd_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  att_wr_t  pgw_wr,
    input  att_wr_t  mgr_wr,
    input  logic     fl_wr_en,
    input  fl_idx_t  fl_wr_idx,
    input  ppn_t     fl_wr_ppa,
    input  logic     free_pop,
    input  att_idx_t rd_idx,
    output logic     rd_valid,
    output ppn_t     rd_ppa,
    output ppn_t     free_head,
    output fcnt_t    free_cnt
);

    logic    att_vld_q [`HAWK_ATT_ENTRIES];
    ppn_t    att_ppa_q [`HAWK_ATT_ENTRIES];
    ppn_t    fl_q [`HAWK_FREE_PAGES];
    fl_idx_t head_q;
    att_wr_t wr;

    // writer first, it only runs during init
    assign wr = pgw_wr.en ? pgw_wr : mgr_wr;

    always_ff @(posedge clk_i) begin
        if (wr.en) begin
            att_vld_q[wr.idx] <= wr.vld;
            att_ppa_q[wr.idx] <= wr.ppa;
        end
        if (fl_wr_en) begin
            fl_q[fl_wr_idx] <= fl_wr_ppa;
        end
        rd_valid <= att_vld_q[rd_idx];
        rd_ppa   <= att_ppa_q[rd_idx];
    end

    assign free_head = fl_q[head_q];

    // list becomes full on its last fill write
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            head_q   <= '0;
            free_cnt <= '0;
        end else if (fl_wr_en && (fl_wr_idx == fl_idx_t'(`HAWK_FREE_PAGES - 1))) begin
            head_q   <= '0;
            free_cnt <= fcnt_t'(`HAWK_FREE_PAGES);
        end else if (free_pop) begin
            head_q   <= head_q + 1'b1;
            free_cnt <= free_cnt - 1'b1;
        end
    end

endmodule

//--- design/hawk_pgrd_mngr.sv
/*
 two-step ATT lookup, reply 2 cycles after the strobe
 hppa and zeroBlkWr must stay stable until the reply
*/
`timescale 1ns/1ps
`include "hawk_cfg.svh"

module hawk_pgrd_mngr import hacd_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  att_lkup_reqpkt_t lkup_reqpkt,
    input  logic             rd_valid,
    input  ppn_t             rd_ppa,
    input  ppn_t             free_head,
    input  fcnt_t            free_cnt,
    output logic             pgrd_mngr_ready,
    output att_idx_t         rd_idx,
    output att_wr_t          mgr_wr,
    output logic             free_pop,
    output trnsl_reqpkt_t    trnsl_reqpkt,
    output tol_updpkt_t      tol_updpkt
);

    logic lkup_s1_q;
    logic miss, alloc;

    // ATT index from the latched hppa, read registered in the strobe cycle
    assign rd_idx = lkup_reqpkt.hppa[ATT_IDX_W-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // second step, decide on the read data
    ////////////////////////////////////////////////////////////////////////////
    assign miss  = lkup_s1_q && !rd_valid;
    // zero-block writes to unmapped pages allocate nothing
    assign alloc = miss && !lkup_reqpkt.zeroBlkWr;

    assign free_pop = alloc;

    // map the popped page
    always_comb begin
        mgr_wr.en  = alloc;
        mgr_wr.idx = rd_idx;
        mgr_wr.vld = 1'b1;
        mgr_wr.ppa = free_head;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lkup_s1_q       <= 1'b0;
            pgrd_mngr_ready <= 1'b1;
            trnsl_reqpkt    <= '0;
            tol_updpkt      <= '0;
        end else begin
            lkup_s1_q <= lkup_reqpkt.lookup;
            // busy from the strobe until the reply
            if (lkup_reqpkt.lookup) begin
                pgrd_mngr_ready <= 1'b0;
            end else if (lkup_s1_q) begin
                pgrd_mngr_ready <= 1'b1;
            end

            trnsl_reqpkt.allow_access <= lkup_s1_q;
            if (lkup_s1_q) begin
                if (rd_valid) begin
                    trnsl_reqpkt.ppa <= ppn_to_addr(rd_ppa);
                    trnsl_reqpkt.sts <= STS_HIT;
                end else if (lkup_reqpkt.zeroBlkWr) begin
                    trnsl_reqpkt.ppa <= ppn_to_addr(ppn_t'(`HAWK_ZERO_PPA));
                    trnsl_reqpkt.sts <= STS_ZERO;
                end else begin
                    trnsl_reqpkt.ppa <= ppn_to_addr(free_head);
                    trnsl_reqpkt.sts <= STS_ALLOC;
                end
            end

            // allocation report with the count left after this pop
            tol_updpkt.valid <= alloc;
            if (alloc) begin
                tol_updpkt.ppa      <= free_head;
                tol_updpkt.free_cnt <= free_cnt - 1'b1;
            end
        end
    end

endmodule

//--- design/hawk_top.sv
/*
 hawk control path top, instances and wires only
 no requests are granted before init_list falls
*/
`timescale 1ns/1ps

module hawk_top import hacd_pkg::*; (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  cpu_reqpkt_t        cpu_rd_reqpkt,
    input  cpu_reqpkt_t        cpu_wr_reqpkt,
    output hawk_cpu_ovrd_pkt_t hawk_cpu_ovrd_rdpkt,
    output hawk_cpu_ovrd_pkt_t hawk_cpu_ovrd_wrpkt,
    output tol_updpkt_t        tol_updpkt,
    output logic               init_list
);

    // init handshake
    logic init_att, init_att_done, init_list_done;

    // lookup path
    att_lkup_reqpkt_t lkup_reqpkt;
    trnsl_reqpkt_t    trnsl_reqpkt;
    logic             pgrd_mngr_ready;

    // memory ports
    att_wr_t  pgw_wr, mgr_wr;
    logic     fl_wr_en, free_pop, rd_valid;
    fl_idx_t  fl_wr_idx;
    ppn_t     fl_wr_ppa, rd_ppa, free_head;
    att_idx_t rd_idx;
    fcnt_t    free_cnt;

    hawk_ctrl_unit ctrl_unit_inst (
        .clk_i, .rst_ni, .init_att_done, .init_list_done, .init_att, .init_list,
        .pgrd_mngr_ready, .trnsl_reqpkt, .lkup_reqpkt,
        .cpu_rd_reqpkt, .cpu_wr_reqpkt, .hawk_cpu_ovrd_rdpkt, .hawk_cpu_ovrd_wrpkt
    );

    hawk_pg_writer pg_writer_inst (
        .clk_i, .rst_ni, .init_att, .init_list, .init_att_done, .init_list_done,
        .pgw_wr, .fl_wr_en, .fl_wr_idx, .fl_wr_ppa
    );

    hawk_att_mem att_mem_inst (
        .clk_i, .rst_ni, .pgw_wr, .mgr_wr, .fl_wr_en, .fl_wr_idx, .fl_wr_ppa,
        .free_pop, .rd_idx, .rd_valid, .rd_ppa, .free_head, .free_cnt
    );

    hawk_pgrd_mngr pgrd_mngr_inst (
        .clk_i, .rst_ni, .lkup_reqpkt, .rd_valid, .rd_ppa, .free_head, .free_cnt,
        .pgrd_mngr_ready, .rd_idx, .mgr_wr, .free_pop, .trnsl_reqpkt, .tol_updpkt
    );

endmodule

//--- testbench/hawk_top_tb.sv
/*
 table-driven request test for hawk_top against a reference ATT model
 hppa values stay below HAWK_ATT_ENTRIES and allocations below HAWK_FREE_PAGES
*/
`timescale 1ns/1ps
`include "hawk_cfg.svh"

module hawk_top_tb import hacd_pkg::*; ();

    localparam int CLK_HALF      = 2;
    localparam int GRANT_LAT     = 4;
    localparam int INIT_TIMEOUT  = 100;
    localparam int GRANT_TIMEOUT = 40;
    localparam int NUM_ENTRIES   = 12;

    // row kinds where a pair row drives both sources in the same cycle
    localparam int K_RD   = 0;
    localparam int K_WR   = 1;
    localparam int K_BOTH = 2;

    typedef struct packed {
        int kind;
        int rd_hppa;
        int wr_hppa;
        int zero;
        int exp_rd;
        int exp_wr;
    } entry_t;

    // kind, rd hppa, wr hppa, zeroBlkWr, expected rd ppa, expected wr ppa
    entry_t tbl [NUM_ENTRIES] = '{
        '{K_RD,    3,  0, 0, 256,   0},
        '{K_RD,    5,  0, 0, 257,   0},
        '{K_RD,    3,  0, 0, 256,   0},
        '{K_WR,    0,  3, 0,   0, 256},
        '{K_WR,    0,  7, 1,   0,   1},
        '{K_WR,    0,  9, 0,   0, 258},
        '{K_WR,    0,  7, 1,   0,   1},
        '{K_RD,    7,  0, 0, 259,   0},
        '{K_BOTH, 10, 11, 0, 261, 260},
        '{K_BOTH,  5,  7, 1, 257, 259},
        '{K_WR,    0, 12, 0,   0, 262},
        '{K_BOTH, 12,  9, 0, 262, 258}
    };

    logic               clk_i;
    logic               rst_ni;
    cpu_reqpkt_t        cpu_rd_reqpkt;
    cpu_reqpkt_t        cpu_wr_reqpkt;
    hawk_cpu_ovrd_pkt_t hawk_cpu_ovrd_rdpkt;
    hawk_cpu_ovrd_pkt_t hawk_cpu_ovrd_wrpkt;
    tol_updpkt_t        tol_updpkt;
    logic               init_list;

    // values sampled mid-cycle away from the clock edge
    hawk_cpu_ovrd_pkt_t rd_grant, wr_grant;
    logic               init_list_s;
    tol_updpkt_t        tol_q[$];
    tol_updpkt_t        exp_tol_q[$];

    // reference ATT model
    bit   att_vld [`HAWK_ATT_ENTRIES];
    int   att_ppa [`HAWK_ATT_ENTRIES];
    int   next_free;
    int   free_left;
    logic last_rd;

    logic [31:0] lfsr;

    hawk_top hawk_top_inst (
        .clk_i, .rst_ni, .cpu_rd_reqpkt, .cpu_wr_reqpkt,
        .hawk_cpu_ovrd_rdpkt, .hawk_cpu_ovrd_wrpkt, .tol_updpkt, .init_list
    );

    always #(CLK_HALF) clk_i = ~clk_i;

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////
    // 32-bit Galois LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    // one LFSR step per bit taken
    function automatic int random_bits(int nbits);
        int v;
        v = 0;
        for (int i = 0; i < nbits; i++) begin
            v = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    task automatic report_failure();
        $display("tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    // sample at the falling edge and return on the rising edge for driving
    task automatic clock_cycle();
        @(negedge clk_i);
        rd_grant    = hawk_cpu_ovrd_rdpkt;
        wr_grant    = hawk_cpu_ovrd_wrpkt;
        init_list_s = init_list;
        if (tol_updpkt.valid) begin
            tol_q.push_back(tol_updpkt);
        end
        @(posedge clk_i);
    endtask

    // a hit returns the mapped page and a zero-block write miss the zero page
    // any other miss takes the next free page
    task automatic model_access(input logic is_rd, input int hppa, input int zero,
                                output int ppa);
        tol_updpkt_t t;
        if (att_vld[hppa]) begin
            ppa = att_ppa[hppa];
        end else if (!is_rd && zero != 0) begin
            ppa = `HAWK_ZERO_PPA;
        end else begin
            ppa           = next_free;
            att_vld[hppa] = 1'b1;
            att_ppa[hppa] = next_free;
            next_free++;
            free_left--;
            t.valid    = 1'b1;
            t.ppa      = ppn_t'(ppa);
            t.free_cnt = fcnt_t'(free_left);
            exp_tol_q.push_back(t);
        end
    endtask

    task automatic check_allocs(input int k);
        tol_updpkt_t got, exp;
        assert (tol_q.size() == exp_tol_q.size()) else begin
            $display("MISMATCH at %0t: row %0d gave %0d allocation reports, expected %0d",
                     $time, k, tol_q.size(), exp_tol_q.size());
            report_failure();
        end
        while (exp_tol_q.size() > 0) begin
            exp = exp_tol_q.pop_front();
            got = tol_q.pop_front();
            assert (got.ppa == exp.ppa && got.free_cnt == exp.free_cnt) else begin
                $display("MISMATCH at %0t: row %0d report ppa %0d cnt %0d, expected %0d cnt %0d",
                         $time, k, got.ppa, got.free_cnt, exp.ppa, exp.free_cnt);
                report_failure();
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // one table row
    ////////////////////////////////////////////////////////////////////////////
    task automatic run_entry(input int k);
        entry_t e;
        logic   src_rd [2];
        int     exp_ppa [2];
        int     tbl_ppa [2];
        int     n_exp;
        int     got;
        int     lat;
        logic   rd_g, wr_g;
        ppn_t   g_ppa;
        e     = tbl[k];
        n_exp = (e.kind == K_BOTH) ? 2 : 1;
        // with both pending, the source not granted last goes first
        src_rd[0] = (e.kind == K_BOTH) ? !last_rd : (e.kind == K_RD);
        src_rd[1] = !src_rd[0];
        for (int i = 0; i < n_exp; i++) begin
            if (src_rd[i]) begin
                model_access(1'b1, e.rd_hppa, 0, exp_ppa[i]);
                tbl_ppa[i] = e.exp_rd;
            end else begin
                model_access(1'b0, e.wr_hppa, e.zero, exp_ppa[i]);
                tbl_ppa[i] = e.exp_wr;
            end
            assert (exp_ppa[i] == tbl_ppa[i]) else begin
                $display("table row %0d does not agree with the ATT model", k);
                report_failure();
            end
        end

        if (e.kind != K_WR) begin
            cpu_rd_reqpkt <= '{valid: 1'b1, hppa: ppn_t'(e.rd_hppa), zeroBlkWr: 1'b0};
        end
        if (e.kind != K_RD) begin
            cpu_wr_reqpkt <= '{valid: 1'b1, hppa: ppn_t'(e.wr_hppa), zeroBlkWr: (e.zero != 0)};
        end

        got = 0;
        lat = 0;
        while (got < n_exp && lat < GRANT_TIMEOUT) begin
            clock_cycle();
            lat++;
            rd_g = rd_grant.allow_access;
            wr_g = wr_grant.allow_access;
            if (rd_g || wr_g) begin
                assert (rd_g != wr_g && rd_g == src_rd[got]) else begin
                    $display("MISMATCH at %0t: row %0d grant %0d came on the %s packet",
                             $time, k, got, rd_g ? "read" : "write");
                    report_failure();
                end
                g_ppa = rd_g ? rd_grant.ppa : wr_grant.ppa;
                assert (g_ppa == ppn_t'(exp_ppa[got])) else begin
                    $display("MISMATCH at %0t: row %0d granted ppa %0d, expected %0d",
                             $time, k, g_ppa, exp_ppa[got]);
                    report_failure();
                end
                // valid is sampled one edge after the drive and the grant is seen one edge late
                if (n_exp == 1) begin
                    assert (lat == GRANT_LAT + 2) else begin
                        $display("MISMATCH at %0t: row %0d grant after %0d edges, expected %0d",
                                 $time, k, lat, GRANT_LAT + 2);
                        report_failure();
                    end
                end
                // source drops valid the cycle after its grant
                if (rd_g) begin
                    cpu_rd_reqpkt.valid <= 1'b0;
                end else begin
                    cpu_wr_reqpkt.valid <= 1'b0;
                end
                last_rd = rd_g;
                got++;
            end
        end
        if (got < n_exp) begin
            $display("timeout waiting for a grant on table row %0d", k);
            report_failure();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        int n;
        int gap;
        clk_i         = 1'b0;
        rst_ni        = 1'b0;
        cpu_rd_reqpkt = '0;
        cpu_wr_reqpkt = '0;
        lfsr          = 32'd70356;
        next_free     = `HAWK_FREE_BASE;
        free_left     = `HAWK_FREE_PAGES;
        // FSM leaves init checking reads first
        last_rd       = 1'b0;

        repeat (4) @(posedge clk_i);
        rst_ni <= 1'b1;

        clock_cycle();
        assert (init_list_s === 1'b1) else begin
            $display("MISMATCH at %0t: init_list not high after reset", $time);
            report_failure();
        end
        n = 0;
        while (init_list_s && n < INIT_TIMEOUT) begin
            clock_cycle();
            n++;
        end
        if (init_list_s) begin
            $display("timeout waiting for init_list to fall");
            report_failure();
        end

        for (int k = 0; k < NUM_ENTRIES; k++) begin
            run_entry(k);
            check_allocs(k);
            // idle gap of 1 to 4 cycles
            gap = random_bits(2) + 1;
            repeat (gap) clock_cycle();
        end
        check_allocs(NUM_ENTRIES);

        $display("all tests passed");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+include
design/hacd_pkg.sv
design/hawk_ctrl_unit.sv
design/hawk_pg_writer.sv
design/hawk_att_mem.sv
design/hawk_pgrd_mngr.sv
design/hawk_top.sv
testbench/hawk_top_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --timing --assert -Wno-fatal
TOP       = hawk_top_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^all tests passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
